/* src.f */
logic/exec_pkg.sv
logic/int_alu.sv
logic/mul_unit.sv
logic/branch_resolve.sv
logic/execute_stage.sv
test/execute_assert.sv
test/execute_checker.sv
test/tb_execute.sv

/* Bender.yml */
package:
  name: execute_stage

sources:
  - files:
      - logic/exec_pkg.sv
      - logic/int_alu.sv
      - logic/mul_unit.sv
      - logic/branch_resolve.sv
      - logic/execute_stage.sv
  - target: test
    files:
      - test/execute_assert.sv
      - test/execute_checker.sv
      - test/tb_execute.sv

/* test/tb_execute.sv */
// Execute stage testbench
module tb_execute;

    localparam int N_INSTR    = 400;
    localparam int RST_CYCLES = 5;
    localparam int CLK_PERIOD = 100;
    localparam int TIMEOUT    = (N_INSTR + RST_CYCLES + 20) * CLK_PERIOD;

    logic        clk_i;
    logic        rst_i;
    logic [8:0]  uop_i;
    logic        rd_we_i;
    logic [4:0]  rd_addr_i;
    logic [31:0] pc_plus4_i;
    logic [31:0] op_a_i;
    logic [31:0] op_b_i;
    logic [31:0] rs1_i;
    logic [31:0] rs2_i;
    logic [1:0]  kind_i;
    logic [31:0] decode_pc_i;
    logic [31:0] redirect_pc_o;
    logic        redirect_valid_o;
    logic        predict_ok_o;
    logic [31:0] wb_value_o;
    logic [4:0]  wb_rd_addr_o;
    logic        wb_we_o;
    logic        done;                      // Tells the checker to report
    logic        report_done;
    int unsigned chk_checks;
    int unsigned chk_fails;
    int unsigned asrt_fails;
    integer      seed;

    execute_stage u_dut (.*);

    execute_checker u_chk (
        .redirect_pc_i (redirect_pc_o), .redirect_valid_i (redirect_valid_o),
        .predict_ok_i  (predict_ok_o),  .wb_value_i       (wb_value_o),
        .wb_rd_addr_i  (wb_rd_addr_o),  .wb_we_i          (wb_we_o),
        .done_i        (done),          .check_count_o    (chk_checks),
        .fail_count_o  (chk_fails),     .report_done_o    (report_done), .*
    );

    bind execute_stage execute_assert u_assert (
        .clk_i (clk_i), .rst_i (rst_i), .kind_i (kind_i),
        .redirect_valid_i (redirect_valid_o), .wb_we_i (wb_we_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] pick(input logic [31:0] n);
        return rand_word() % n;             // Uniform-ish in 0..n-1
    endfunction

    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = pick(8);
        if (r != 0) return rand_word();
        r = pick(4);                        // Extremes for multiply and compare corners
        return (r == 0) ? 32'h8000_0000 : (r == 1) ? 32'hFFFF_FFFF
             : (r == 2) ? 32'h0000_0000 : 32'h7FFF_FFFF;
    endfunction

    task automatic drive_instr();
        logic [31:0] r;
        logic [31:0] pc;
        logic [3:0]  op;
        r = (pick(10) == 0) ? 32'd3 : pick(3);                 // Spare unit about 1 in 10
        uop_i[8:7] = r[1:0];
        r = (pick(10) == 0) ? 32'd11 + pick(5) : pick(11);    // Undefined ALU codes 11..15
        op = r[3:0];
        r = (pick(10) == 0) ? 32'd7 : pick(7);
        uop_i[2:0] = r[2:0];
        r = (pick(10) == 0) ? 32'd3 : pick(3);
        kind_i = r[1:0];
        if (kind_i inside {exec_pkg::KIND_JUMP, exec_pkg::KIND_BRANCH}
            && uop_i[8:7] != exec_pkg::UNIT_MUL) op = exec_pkg::ALU_ADD;  // Target = a + b
        uop_i[6:3] = op;
        op_a_i = pick_operand();
        op_b_i = pick_operand();
        rs1_i  = pick_operand();
        r = pick(4);
        rs2_i  = (r == 0) ? rs1_i : (r == 1) ? rs1_i ^ 32'h8000_0000 : pick_operand();
        pc = rand_word() & 32'hFFFF_FFFC;
        pc_plus4_i = pc + 32'd4;
        r = pick(4);                        // Right path about half the time
        decode_pc_i = (r < 2) ? pc_plus4_i : (r == 2) ? op_a_i + op_b_i : pc + 32'd12;
        r = rand_word();
        rd_we_i   = r[0];
        rd_addr_i = r[5:1];
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout: run did not finish within %0d time units", TIMEOUT);
        $display("sim failed");
        $finish;
    end

    initial begin
        seed = 32'h3f7e;
        done = 1'b0;
        rst_i = 1'b1;
        {uop_i, rd_we_i, rd_addr_i, kind_i} = '0;
        {pc_plus4_i, op_a_i, op_b_i, rs1_i, rs2_i, decode_pc_i} = '0;
        repeat (RST_CYCLES - 1) begin
            @(posedge clk_i);
            #10;
            drive_instr();                  // Live inputs that reset must hold off
        end
        @(posedge clk_i);
        for (int i = 0; i < N_INSTR; i++) begin
            if (i > 0) @(posedge clk_i);
            #10;
            rst_i = 1'b0;
            drive_instr();
        end
        @(posedge clk_i);
        #10;
        {uop_i, rd_we_i, kind_i} = '0;      // Idle slot flushes the last writeback
        repeat (2) @(posedge clk_i);
        #10;
        done = 1'b1;
        wait (report_done === 1'b1);
        asrt_fails = u_dut.u_assert.fail_count;
        $display("closing: %0d checks, %0d check failures, %0d assertion failures",
                 chk_checks, chk_fails, asrt_fails);
        if (chk_fails == 0 && asrt_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* test/execute_checker.sv */
// Execute stage reference checker
module execute_checker (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic [8:0]  uop_i,              // Unit [8:7], op [6:3], cond [2:0]
    input  logic        rd_we_i,
    input  logic [4:0]  rd_addr_i,
    input  logic [31:0] pc_plus4_i,
    input  logic [31:0] op_a_i,
    input  logic [31:0] op_b_i,
    input  logic [31:0] rs1_i,
    input  logic [31:0] rs2_i,
    input  logic [1:0]  kind_i,
    input  logic [31:0] decode_pc_i,
    input  logic [31:0] redirect_pc_i,
    input  logic        redirect_valid_i,
    input  logic        predict_ok_i,
    input  logic [31:0] wb_value_i,
    input  logic [4:0]  wb_rd_addr_i,
    input  logic        wb_we_i,
    input  logic        done_i,             // Stimulus finished
    output int unsigned check_count_o,
    output int unsigned fail_count_o,
    output logic        report_done_o
);

    string       names [6] = '{"reset", "alu", "mul", "link", "redirect", "predict"};
    int unsigned checks [6];
    int unsigned fails [6];
    logic        have_exp;                  // Writeback expectation is pending
    logic [31:0] exp_value;
    logic [4:0]  exp_addr;
    logic        exp_we;
    int          exp_test;                  // Test the pending writeback belongs to
    logic [31:0] exp_target;
    logic        exp_taken;
    logic        reset_shown;

    function automatic logic [31:0] ref_alu(input logic [3:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [63:0] wide;
        logic [31:0] r;
        wide = {{32{a[31]}}, a} >> b[4:0];  // Arithmetic shift by sign-extending first
        case (op)
            exec_pkg::ALU_ADD:   r = a + b;
            exec_pkg::ALU_SUB:   r = a - b;
            exec_pkg::ALU_AND:   r = a & b;
            exec_pkg::ALU_OR:    r = a | b;
            exec_pkg::ALU_XOR:   r = a ^ b;
            exec_pkg::ALU_SLL:   r = a << b[4:0];
            exec_pkg::ALU_SRL:   r = a >> b[4:0];
            exec_pkg::ALU_SRA:   r = wide[31:0];
            exec_pkg::ALU_SLT:   r = {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            exec_pkg::ALU_SLTU:  r = {31'd0, a < b};
            exec_pkg::ALU_PASSB: r = b;
            default:             r = 32'd0;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] ref_mul(input logic [1:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [63:0] ax;
        logic [63:0] bx;
        logic [63:0] p;
        ax = {32'd0, a};
        bx = {32'd0, b};
        if (op == exec_pkg::MUL_HI_SS || op == exec_pkg::MUL_HI_SU) ax[63:32] = {32{a[31]}};
        if (op == exec_pkg::MUL_HI_SS) bx[63:32] = {32{b[31]}};
        p = ax * bx;                        // Modulo 2^64 gives the right high word
        return (op == exec_pkg::MUL_LO) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic ref_taken(input logic [1:0] kind, input logic [2:0] cond,
                                       input logic [31:0] x, input logic [31:0] y);
        logic lt;
        logic hold;
        lt = (x ^ 32'h8000_0000) < (y ^ 32'h8000_0000);
        case (cond)
            exec_pkg::COND_EQ:  hold = x == y;
            exec_pkg::COND_NE:  hold = x != y;
            exec_pkg::COND_LT:  hold = lt;
            exec_pkg::COND_GE:  hold = !lt;
            exec_pkg::COND_LTU: hold = x < y;
            exec_pkg::COND_GEU: hold = x >= y;
            default:            hold = 1'b0;  // NONE and spare codes
        endcase
        return (kind == exec_pkg::KIND_JUMP) || (kind == exec_pkg::KIND_BRANCH && hold);
    endfunction

    task automatic check(input int t, input logic ok, input string msg);
        checks[t]++;
        if (ok !== 1'b1) begin
            fails[t]++;
            $display("CHECK FAILED at %0t: %s", $time, msg);
        end
    endtask

    task automatic show_test(input int t);
        $display("test %s done: %0d checks, %0d failed", names[t], checks[t], fails[t]);
    endtask

    initial begin
        have_exp    = 1'b0;
        reset_shown = 1'b0;
        foreach (checks[t]) begin
            checks[t] = 0;
            fails[t]  = 0;
        end
        forever begin
            @(posedge clk_i);
            #99;                                        // Settled, just before next edge
            if (have_exp) begin
                check(exp_test, wb_value_i === exp_value && wb_rd_addr_i === exp_addr
                      && wb_we_i === exp_we,
                      $sformatf("wb %h rd %0d we %b, expected %h rd %0d we %b",
                                wb_value_i, wb_rd_addr_i, wb_we_i, exp_value, exp_addr, exp_we));
                if (exp_test != 0 && !reset_shown) begin
                    show_test(0);                       // Reset phase is over
                    reset_shown = 1'b1;
                end
            end
            if (!rst_i) begin
                exp_target = ref_alu(uop_i[6:3], op_a_i, op_b_i);  // ALU feeds the target
                exp_taken  = ref_taken(kind_i, uop_i[2:0], rs1_i, rs2_i);
                check(4, redirect_pc_i === exp_target && redirect_valid_i === exp_taken,
                      $sformatf("redirect %h valid %b, expected %h valid %b",
                                redirect_pc_i, redirect_valid_i, exp_target, exp_taken));
                check(5, predict_ok_i === (decode_pc_i == (exp_taken ? exp_target : pc_plus4_i)),
                      $sformatf("predict_ok %b wrong for decode pc %h", predict_ok_i, decode_pc_i));
            end
            // Expectation for the edge that ends this cycle
            have_exp  = 1'b1;
            exp_addr  = rst_i ? 5'd0 : rd_addr_i;
            exp_we    = rst_i ? 1'b0 : rd_we_i;
            exp_test  = rst_i ? 0 : (uop_i[8:7] == exec_pkg::UNIT_ALU) ? 1
                      : (uop_i[8:7] == exec_pkg::UNIT_MUL) ? 2 : 3;
            case (exp_test)
                1:       exp_value = ref_alu(uop_i[6:3], op_a_i, op_b_i);
                2:       exp_value = ref_mul(uop_i[4:3], op_a_i, op_b_i);
                3:       exp_value = (uop_i[8:7] == exec_pkg::UNIT_LINK) ? pc_plus4_i : 32'd0;
                default: exp_value = 32'd0;
            endcase
        end
    end

    initial begin
        report_done_o = 1'b0;
        check_count_o = 0;
        fail_count_o  = 0;
        wait (done_i === 1'b1);
        for (int t = 1; t < 6; t++) begin
            show_test(t);
        end
        foreach (checks[t]) begin
            check_count_o += checks[t];
            fail_count_o  += fails[t];
        end
        report_done_o = 1'b1;
    end

endmodule

/* test/execute_assert.sv */
// Execute stage assertions
module execute_assert (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic [1:0] kind_i,            // Instruction kind from decode
    input  logic       redirect_valid_i,  // Bound to redirect_valid_o
    input  logic       wb_we_i            // Bound to wb_we_o
);

    int unsigned fail_count = 0;          // Read by the testbench top

    reset_clears_we: assert property (@(posedge clk_i) rst_i |=> !wb_we_i)
        else begin
            $error("write enable still set after a reset edge");
            fail_count++;
        end

    jump_redirects: assert property (@(posedge clk_i) disable iff (rst_i)
        (kind_i == exec_pkg::KIND_JUMP) |-> redirect_valid_i)
        else begin
            $error("jump did not raise a redirect");
            fail_count++;
        end

    other_no_redirect: assert property (@(posedge clk_i) disable iff (rst_i)
        (kind_i == exec_pkg::KIND_OTHER) |-> !redirect_valid_i)
        else begin
            $error("non-control instruction raised a redirect");
            fail_count++;
        end

endmodule

/* logic/execute_stage.sv */
// Execute stage top
module execute_stage (
    input  logic                            clk_i,
    input  logic                            rst_i,

    // From decode
    input  logic [exec_pkg::UOP_W-1:0]      uop_i,             // Unit, operation, condition
    input  logic                            rd_we_i,           // Instruction writes rd
    input  logic [exec_pkg::REG_ADDR_W-1:0] rd_addr_i,         // Destination register
    input  logic [exec_pkg::XLEN-1:0]       pc_plus4_i,        // Link value for JAL and JALR
    input  logic [exec_pkg::XLEN-1:0]       op_a_i,            // Forwarded and imm-selected
    input  logic [exec_pkg::XLEN-1:0]       op_b_i,
    input  logic [exec_pkg::XLEN-1:0]       rs1_i,             // Raw values for compare
    input  logic [exec_pkg::XLEN-1:0]       rs2_i,
    input  logic [1:0]                      kind_i,            // Jump, branch or other
    input  logic [exec_pkg::XLEN-1:0]       decode_pc_i,       // Next instruction's PC

    // Same-cycle redirect to fetch
    output logic [exec_pkg::XLEN-1:0]       redirect_pc_o,
    output logic                            redirect_valid_o,
    output logic                            predict_ok_o,      // Fetched path was right

    // Writeback, one cycle later
    output logic [exec_pkg::XLEN-1:0]       wb_value_o,
    output logic [exec_pkg::REG_ADDR_W-1:0] wb_rd_addr_o,
    output logic                            wb_we_o
);

    logic [exec_pkg::UOP_UNIT_W-1:0] unit_sel;                 // Result source
    logic [exec_pkg::UOP_OP_W-1:0]   op_code;                  // ALU or multiply code
    logic [exec_pkg::UOP_COND_W-1:0] cond_code;                // Branch condition
    logic [exec_pkg::XLEN-1:0]       alu_result;
    logic [exec_pkg::XLEN-1:0]       mul_result;
    logic [exec_pkg::XLEN-1:0]       wb_value_next;

    // Micro-op fields
    assign unit_sel  = uop_i[exec_pkg::UOP_UNIT_LSB +: exec_pkg::UOP_UNIT_W];
    assign op_code   = uop_i[exec_pkg::UOP_OP_LSB +: exec_pkg::UOP_OP_W];
    assign cond_code = uop_i[exec_pkg::UOP_COND_LSB +: exec_pkg::UOP_COND_W];

    int_alu u_alu (
        .op_i     (op_code),
        .a_i      (op_a_i),
        .b_i      (op_b_i),
        .result_o (alu_result)
    );

    mul_unit u_mul (
        .op_i     (op_code[1:0]),                              // Multiplier reads low bits
        .a_i      (op_a_i),
        .b_i      (op_b_i),
        .result_o (mul_result)
    );

    branch_resolve u_branch (
        .cond_i           (cond_code),
        .kind_i           (kind_i),
        .rs1_i            (rs1_i),
        .rs2_i            (rs2_i),
        .target_i         (alu_result),                        // PC+imm or rs1+imm
        .pc_plus4_i       (pc_plus4_i),
        .decode_pc_i      (decode_pc_i),
        .redirect_pc_o    (redirect_pc_o),
        .redirect_valid_o (redirect_valid_o),
        .predict_ok_o     (predict_ok_o)
    );

    // Writeback source select
    always_comb begin
        case (unit_sel)
            exec_pkg::UNIT_ALU:  wb_value_next = alu_result;
            exec_pkg::UNIT_MUL:  wb_value_next = mul_result;
            exec_pkg::UNIT_LINK: wb_value_next = pc_plus4_i;   // rd = PC+4
            default:             wb_value_next = '0;           // Spare unit code
        endcase
    end

    // Writeback pipeline register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_value_o   <= '0;
            wb_rd_addr_o <= '0;
            wb_we_o      <= 1'b0;
        end else begin
            wb_value_o   <= wb_value_next;
            wb_rd_addr_o <= rd_addr_i;
            wb_we_o      <= rd_we_i;
        end
    end

endmodule

/* logic/branch_resolve.sv */
// Branch and jump resolution
module branch_resolve (
    input  logic [exec_pkg::UOP_COND_W-1:0] cond_i,           // Branch condition code
    input  logic [1:0]                      kind_i,           // Instruction kind
    input  logic [exec_pkg::XLEN-1:0]       rs1_i,            // Raw compare operands
    input  logic [exec_pkg::XLEN-1:0]       rs2_i,
    input  logic [exec_pkg::XLEN-1:0]       target_i,         // Computed by the ALU
    input  logic [exec_pkg::XLEN-1:0]       pc_plus4_i,       // Fall-through address
    input  logic [exec_pkg::XLEN-1:0]       decode_pc_i,      // PC now sitting in decode
    output logic [exec_pkg::XLEN-1:0]       redirect_pc_o,
    output logic                            redirect_valid_o,
    output logic                            predict_ok_o
);

    logic eq;                                   // rs1 == rs2
    logic lt;                                   // rs1 < rs2 signed
    logic ltu;                                  // rs1 < rs2 unsigned
    logic cond_hold;                            // Condition met

    assign eq  = rs1_i == rs2_i;
    assign lt  = $signed(rs1_i) < $signed(rs2_i);
    assign ltu = rs1_i < rs2_i;

    always_comb begin
        case (cond_i)
            exec_pkg::COND_NONE: cond_hold = 1'b0;
            exec_pkg::COND_EQ:   cond_hold = eq;
            exec_pkg::COND_NE:   cond_hold = !eq;
            exec_pkg::COND_LT:   cond_hold = lt;
            exec_pkg::COND_GE:   cond_hold = !lt;
            exec_pkg::COND_LTU:  cond_hold = ltu;
            exec_pkg::COND_GEU:  cond_hold = !ltu;
            default:             cond_hold = 1'b0;  // Never redirect on a bad code
        endcase
    end

    always_comb begin
        case (kind_i)
            exec_pkg::KIND_OTHER:  redirect_valid_o = 1'b0;
            exec_pkg::KIND_JUMP:   redirect_valid_o = 1'b1;       // Unconditional
            exec_pkg::KIND_BRANCH: redirect_valid_o = cond_hold;
            default:               redirect_valid_o = 1'b0;
        endcase
    end

    assign redirect_pc_o = target_i;

    // Decode should hold the target when taken and PC+4 otherwise
    assign predict_ok_o = decode_pc_i == (redirect_valid_o ? target_i : pc_plus4_i);

endmodule

/* logic/mul_unit.sv */
// Single-cycle multiplier
module mul_unit (
    input  logic [1:0]                op_i,      // Multiply code from low op bits
    input  logic [exec_pkg::XLEN-1:0] a_i,       // Multiplicand
    input  logic [exec_pkg::XLEN-1:0] b_i,       // Multiplier
    output logic [exec_pkg::XLEN-1:0] result_o   // Selected product word
);

    logic                            a_sgn;      // Treat a as signed
    logic                            b_sgn;      // Treat b as signed
    logic signed [exec_pkg::XLEN:0]  a_ext;      // One extra bit for sign or zero
    logic signed [exec_pkg::XLEN:0]  b_ext;
    logic signed [2*exec_pkg::XLEN+1:0] prod;    // Full product of the extended operands

    always_comb begin
        case (op_i)
            exec_pkg::MUL_HI_SS: begin
                a_sgn = 1'b1;
                b_sgn = 1'b1;
            end
            exec_pkg::MUL_HI_SU: begin
                a_sgn = 1'b1;
                b_sgn = 1'b0;                    // MULHSU keeps rs2 unsigned
            end
            exec_pkg::MUL_HI_UU: begin
                a_sgn = 1'b0;
                b_sgn = 1'b0;
            end
            default: begin
                a_sgn = 1'b0;                    // Low word is the same either way
                b_sgn = 1'b0;
            end
        endcase
    end

    assign a_ext = {a_sgn & a_i[exec_pkg::XLEN-1], a_i};
    assign b_ext = {b_sgn & b_i[exec_pkg::XLEN-1], b_i};
    assign prod  = a_ext * b_ext;                // Signed multiply of 33-bit values

    assign result_o = (op_i == exec_pkg::MUL_LO) ? prod[exec_pkg::XLEN-1:0]
                                                 : prod[2*exec_pkg::XLEN-1:exec_pkg::XLEN];

endmodule

/* logic/int_alu.sv */
// Integer ALU
module int_alu (
    input  logic [exec_pkg::UOP_OP_W-1:0] op_i,     // ALU operation code
    input  logic [exec_pkg::XLEN-1:0]     a_i,      // First operand, rs1 or PC
    input  logic [exec_pkg::XLEN-1:0]     b_i,      // Second operand, rs2 or immediate
    output logic [exec_pkg::XLEN-1:0]     result_o  // Also used as jump target
);

    logic [$clog2(exec_pkg::XLEN)-1:0] shamt;       // Shift amount from low bits of b
    logic                              lt_s;        // a < b signed
    logic                              lt_u;        // a < b unsigned

    assign shamt = b_i[$clog2(exec_pkg::XLEN)-1:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            exec_pkg::ALU_ADD: begin
                result_o = a_i + b_i;               // Also address generation
            end
            exec_pkg::ALU_SUB: begin
                result_o = a_i - b_i;
            end
            exec_pkg::ALU_AND: begin
                result_o = a_i & b_i;
            end
            exec_pkg::ALU_OR: begin
                result_o = a_i | b_i;
            end
            exec_pkg::ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            exec_pkg::ALU_SLL: begin
                result_o = a_i << shamt;
            end
            exec_pkg::ALU_SRL: begin
                result_o = a_i >> shamt;            // Zero fill
            end
            exec_pkg::ALU_SRA: begin
                result_o = $signed(a_i) >>> shamt;  // Sign fill
            end
            exec_pkg::ALU_SLT: begin
                result_o = {{(exec_pkg::XLEN-1){1'b0}}, lt_s};
            end
            exec_pkg::ALU_SLTU: begin
                result_o = {{(exec_pkg::XLEN-1){1'b0}}, lt_u};
            end
            exec_pkg::ALU_PASSB: begin
                result_o = b_i;                     // LUI takes the immediate as is
            end
            default: begin
                result_o = '0;                      // Unused codes stay known
            end
        endcase
    end

endmodule

/* logic/exec_pkg.sv */
// Execute stage definitions
package exec_pkg;

    localparam int unsigned XLEN       = 32;              // Data path width
    localparam int unsigned REG_ADDR_W = 5;               // Register file address width

    // Micro-op word layout
    localparam int unsigned UOP_W        = 9;             // Whole micro-op
    localparam int unsigned UOP_UNIT_LSB = 7;             // Unit select at [8:7]
    localparam int unsigned UOP_UNIT_W   = 2;
    localparam int unsigned UOP_OP_LSB   = 3;             // Operation at [6:3]
    localparam int unsigned UOP_OP_W     = 4;
    localparam int unsigned UOP_COND_LSB = 0;             // Branch condition at [2:0]
    localparam int unsigned UOP_COND_W   = 3;

    localparam logic [1:0] UNIT_ALU  = 2'd0;              // Write back ALU result
    localparam logic [1:0] UNIT_MUL  = 2'd1;              // Write back multiplier result
    localparam logic [1:0] UNIT_LINK = 2'd2;              // Write back PC+4

    localparam logic [3:0] ALU_ADD   = 4'd0;
    localparam logic [3:0] ALU_SUB   = 4'd1;
    localparam logic [3:0] ALU_AND   = 4'd2;
    localparam logic [3:0] ALU_OR    = 4'd3;
    localparam logic [3:0] ALU_XOR   = 4'd4;
    localparam logic [3:0] ALU_SLL   = 4'd5;
    localparam logic [3:0] ALU_SRL   = 4'd6;
    localparam logic [3:0] ALU_SRA   = 4'd7;
    localparam logic [3:0] ALU_SLT   = 4'd8;              // Signed compare
    localparam logic [3:0] ALU_SLTU  = 4'd9;              // Unsigned compare
    localparam logic [3:0] ALU_PASSB = 4'd10;             // Upper immediate path

    localparam logic [1:0] MUL_LO    = 2'd0;              // Low product word
    localparam logic [1:0] MUL_HI_SS = 2'd1;              // High word, signed x signed
    localparam logic [1:0] MUL_HI_SU = 2'd2;              // High word, signed x unsigned
    localparam logic [1:0] MUL_HI_UU = 2'd3;              // High word, unsigned x unsigned

    localparam logic [2:0] COND_NONE = 3'd0;              // Never taken
    localparam logic [2:0] COND_EQ   = 3'd1;
    localparam logic [2:0] COND_NE   = 3'd2;
    localparam logic [2:0] COND_LT   = 3'd3;
    localparam logic [2:0] COND_GE   = 3'd4;
    localparam logic [2:0] COND_LTU  = 3'd5;
    localparam logic [2:0] COND_GEU  = 3'd6;

    localparam logic [1:0] KIND_OTHER  = 2'd0;            // No control transfer
    localparam logic [1:0] KIND_JUMP   = 2'd1;            // JAL and JALR
    localparam logic [1:0] KIND_BRANCH = 2'd2;            // Conditional branch

endpackage
